//--- Makefile
# Verilator flow for the IMU SPI link
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= imu_spi_link_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
logic/imu_link_pkg.sv
logic/imu_sample_if.sv
logic/sensor_sample_hold.sv
logic/frame_snapshot.sv
logic/spi_miso_shifter.sv
logic/imu_spi_link_top.sv
test/imu_spi_link_assertions.sv
test/imu_spi_link_tb.sv

//--- logic/frame_snapshot.sv
`timescale 1ns/10ps

module frame_snapshot
    import imu_link_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cs_fall_pulse,    // From the chip-select synchronizer
    imu_sample_if.reader smp,
    output frame_u       frame             // Coherent frame for the shifter
);

    // Capture request back to the holder so it can clear its flags
    assign smp.snap = cs_fall_pulse;

    // ----------------------------------------------------------------------
    // Frame register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Header is valid even before the first capture
            frame.fields.header     <= header_byte;
            frame.fields.quat_w     <= '0;
            frame.fields.quat_x     <= '0;
            frame.fields.quat_y     <= '0;
            frame.fields.quat_z     <= '0;
            frame.fields.gyro_x     <= '0;
            frame.fields.gyro_y     <= '0;
            frame.fields.gyro_z     <= '0;
            frame.fields.pad        <= '0;
            frame.fields.gyro_fresh <= 1'b0;
            frame.fields.quat_fresh <= 1'b0;
        end else if (cs_fall_pulse) begin
            frame.fields.header     <= header_byte;
            frame.fields.quat_w     <= smp.quat_w;      // Quaternion block
            frame.fields.quat_x     <= smp.quat_x;
            frame.fields.quat_y     <= smp.quat_y;
            frame.fields.quat_z     <= smp.quat_z;
            frame.fields.gyro_x     <= smp.gyro_x;      // Gyro block
            frame.fields.gyro_y     <= smp.gyro_y;
            frame.fields.gyro_z     <= smp.gyro_z;
            frame.fields.pad        <= '0;
            frame.fields.gyro_fresh <= smp.gyro_fresh;  // Flags as seen before the clear
            frame.fields.quat_fresh <= smp.quat_fresh;
        end
        // Otherwise hold, sensor updates wait for the next chip select
    end

endmodule

//--- logic/imu_link_pkg.sv
package imu_link_pkg;

    // ----------------------------------------------------------------------
    // Frame geometry
    // ----------------------------------------------------------------------
    localparam int unsigned frame_bytes = 16;       // Header, 14 data bytes, flags
    localparam logic [7:0]  header_byte = 8'hAA;    // Sync byte at frame start
    localparam int unsigned word_w      = 16;       // Sensor word width

    typedef logic [3:0] byte_idx_t;                 // Byte position 0..15

    // Field view of one frame
    // Declaration order matches wire order, header goes out first
    typedef struct packed {
        logic [7:0]               header;           // Always header_byte
        logic signed [word_w-1:0] quat_w;           // Quaternion real part
        logic signed [word_w-1:0] quat_x;
        logic signed [word_w-1:0] quat_y;
        logic signed [word_w-1:0] quat_z;
        logic signed [word_w-1:0] gyro_x;           // Angular rate
        logic signed [word_w-1:0] gyro_y;
        logic signed [word_w-1:0] gyro_z;
        logic [5:0]               pad;              // Reserved bits of flag byte
        logic                     gyro_fresh;       // Flag byte bit 1
        logic                     quat_fresh;       // Flag byte bit 0
    } frame_fields_t;

    // Same 128 bits seen as bytes
    // Ascending packed range puts bytes[0] in the top 8 bits
    typedef union packed {
        frame_fields_t                 fields;      // Written by the snapshot
        logic [0:frame_bytes-1][7:0]   bytes;       // Read by the shifter
    } frame_u;

endpackage

//--- logic/imu_sample_if.sv
`timescale 1ns/10ps

// Held sensor sample between the input side and the snapshot logic
interface imu_sample_if
    import imu_link_pkg::*;
();

    logic signed [word_w-1:0] quat_w;       // Latest quaternion
    logic signed [word_w-1:0] quat_x;
    logic signed [word_w-1:0] quat_y;
    logic signed [word_w-1:0] quat_z;
    logic signed [word_w-1:0] gyro_x;       // Latest gyroscope rates
    logic signed [word_w-1:0] gyro_y;
    logic signed [word_w-1:0] gyro_z;
    logic                     quat_fresh;   // New quaternion since last frame
    logic                     gyro_fresh;   // New gyro sample since last frame
    logic                     snap;         // One-cycle capture request

    modport holder (
        output quat_w, quat_x, quat_y, quat_z,
        output gyro_x, gyro_y, gyro_z,
        output quat_fresh, gyro_fresh,
        input  snap
    );

    modport reader (
        input  quat_w, quat_x, quat_y, quat_z,
        input  gyro_x, gyro_y, gyro_z,
        input  quat_fresh, gyro_fresh,
        output snap
    );

endinterface

//--- logic/imu_spi_link_top.sv
`timescale 1ns/10ps

module imu_spi_link_top
    import imu_link_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cs_n,          // SPI select from the host
    input  logic                     sck,           // SPI clock from the host
    input  logic                     quat_strobe,   // New quaternion sample
    input  logic                     gyro_strobe,   // New gyro sample
    input  logic signed [word_w-1:0] quat_w,
    input  logic signed [word_w-1:0] quat_x,
    input  logic signed [word_w-1:0] quat_y,
    input  logic signed [word_w-1:0] quat_z,
    input  logic signed [word_w-1:0] gyro_x,
    input  logic signed [word_w-1:0] gyro_y,
    input  logic signed [word_w-1:0] gyro_z,
    output logic                     sdo,           // MISO toward the pad
    output logic                     sdo_oe         // MISO pad enable
);

    imu_sample_if smp_if ();        // Held sample, holder to snapshot

    frame_u frame_w;                // Snapshot to shifter
    logic   cs_fall_pulse;          // Shifter to snapshot

    // Input side
    sensor_sample_hold u_hold (
        .clk         (clk),
        .rst_n       (rst_n),
        .quat_strobe (quat_strobe),
        .gyro_strobe (gyro_strobe),
        .quat_w_in   (quat_w),
        .quat_x_in   (quat_x),
        .quat_y_in   (quat_y),
        .quat_z_in   (quat_z),
        .gyro_x_in   (gyro_x),
        .gyro_y_in   (gyro_y),
        .gyro_z_in   (gyro_z),
        .smp         (smp_if.holder)
    );

    // Processing part
    frame_snapshot u_snap (
        .clk           (clk),
        .rst_n         (rst_n),
        .cs_fall_pulse (cs_fall_pulse),
        .smp           (smp_if.reader),
        .frame         (frame_w)
    );

    // Output side
    spi_miso_shifter u_shift (
        .clk           (clk),
        .rst_n         (rst_n),
        .cs_n          (cs_n),
        .sck           (sck),
        .frame         (frame_w),
        .cs_fall_pulse (cs_fall_pulse),
        .sdo           (sdo),
        .sdo_oe        (sdo_oe)
    );

endmodule

//--- logic/sensor_sample_hold.sv
`timescale 1ns/10ps

module sensor_sample_hold
    import imu_link_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     quat_strobe,   // Quaternion words valid this cycle
    input  logic                     gyro_strobe,   // Gyro words valid this cycle
    input  logic signed [word_w-1:0] quat_w_in,
    input  logic signed [word_w-1:0] quat_x_in,
    input  logic signed [word_w-1:0] quat_y_in,
    input  logic signed [word_w-1:0] quat_z_in,
    input  logic signed [word_w-1:0] gyro_x_in,
    input  logic signed [word_w-1:0] gyro_y_in,
    input  logic signed [word_w-1:0] gyro_z_in,
    imu_sample_if.holder             smp
);

    // ----------------------------------------------------------------------
    // Quaternion holding register and flag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            smp.quat_w     <= '0;
            smp.quat_x     <= '0;
            smp.quat_y     <= '0;
            smp.quat_z     <= '0;
            smp.quat_fresh <= 1'b0;
        end else if (quat_strobe) begin
            smp.quat_w     <= quat_w_in;
            smp.quat_x     <= quat_x_in;
            smp.quat_y     <= quat_y_in;
            smp.quat_z     <= quat_z_in;
            smp.quat_fresh <= 1'b1;         // Set wins over a coincident snap
        end else if (smp.snap) begin
            smp.quat_fresh <= 1'b0;         // Reported in the frame being captured
        end
    end

    // ----------------------------------------------------------------------
    // Gyroscope holding register and flag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            smp.gyro_x     <= '0;
            smp.gyro_y     <= '0;
            smp.gyro_z     <= '0;
            smp.gyro_fresh <= 1'b0;
        end else if (gyro_strobe) begin
            smp.gyro_x     <= gyro_x_in;
            smp.gyro_y     <= gyro_y_in;
            smp.gyro_z     <= gyro_z_in;
            smp.gyro_fresh <= 1'b1;
        end else if (smp.snap) begin
            smp.gyro_fresh <= 1'b0;
        end
    end

    // A strobe in the snap cycle still lands here,
    // but the snapshot takes the values from before that edge

endmodule

//--- logic/spi_miso_shifter.sv
`timescale 1ns/10ps

module spi_miso_shifter
    import imu_link_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cs_n,            // Chip select pin, active low
    input  logic   sck,             // SPI clock pin, mode 0
    input  frame_u frame,           // Snapshot to send
    output logic   cs_fall_pulse,   // One cycle when the select becomes active
    output logic   sdo,             // MISO data
    output logic   sdo_oe           // Pad enable for MISO
);

    // ----------------------------------------------------------------------
    // Pin synchronizers
    // ----------------------------------------------------------------------
    logic cs_act_meta;              // First stage, active-high select
    logic cs_act;                   // Synchronized select
    logic cs_act_prev;              // For edge detection
    logic sck_meta;
    logic sck_sync;
    logic sck_prev;
    logic sck_fall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cs_act_meta <= 1'b0;    // Idle is deselected
            cs_act      <= 1'b0;
            cs_act_prev <= 1'b0;
            sck_meta    <= 1'b0;    // Mode 0 idles low
            sck_sync    <= 1'b0;
            sck_prev    <= 1'b0;
        end else begin
            cs_act_meta <= ~cs_n;
            cs_act      <= cs_act_meta;
            cs_act_prev <= cs_act;
            sck_meta    <= sck;
            sck_sync    <= sck_meta;
            sck_prev    <= sck_sync;
        end
    end

    assign cs_fall_pulse = cs_act & ~cs_act_prev;  // Select just went active
    assign sck_fall      = sck_prev & ~sck_sync;   // Host is done sampling this bit

    // ----------------------------------------------------------------------
    // Shift register and counters
    // ----------------------------------------------------------------------
    logic [7:0] shift_reg;          // Bit 7 is on the wire
    logic [2:0] bit_cnt;            // Bits already sent of the current byte
    byte_idx_t  byte_cnt;           // Byte now in shift_reg
    byte_idx_t  next_byte;

    assign next_byte = byte_cnt + byte_idx_t'(1);

    always_ff @(posedge clk) begin
        if (!rst_n || !cs_act) begin
            // Reset or deselected, restart at byte 0
            shift_reg <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
        end else if (cs_fall_pulse) begin
            // Header lands in the same edge as the new snapshot
            shift_reg <= frame.bytes[0];
            bit_cnt   <= '0;
            byte_cnt  <= '0;
        end else if (sck_fall) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                // Byte finished
                if (byte_cnt < byte_idx_t'(frame_bytes - 1)) begin
                    byte_cnt  <= next_byte;
                    shift_reg <= frame.bytes[next_byte];
                end else begin
                    shift_reg <= '0;        // Past the frame end, send zeros
                end
            end else begin
                shift_reg <= {shift_reg[6:0], 1'b0};  // Next bit up to bit 7
            end
        end
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------
    assign sdo    = shift_reg[7];
    assign sdo_oe = cs_act;         // Drive only while selected

endmodule

//--- test/frame_input.txt
# name qw qx qy qz gx gy gz (hex) | quat_strobe gyro_strobe mid_frame | bytes_to_read | flags (hex)
# mid_frame=1 applies the strobes during byte 2 of the read instead of before it
both_strobes    4000 0123 FEDC 8001 0011 FFEE 7FFF 1 1 0 16 03
no_new_sample   0000 0000 0000 0000 0000 0000 0000 0 0 0 16 00
gyro_only       0000 0000 0000 0000 1234 ABCD 0F0F 0 1 0 16 02
mid_frame_upd   2D41 C0DE 5555 AAAA F00D 0BAD 3C3C 1 1 1 16 00
after_mid_upd   0000 0000 0000 0000 0000 0000 0000 0 0 0 16 03
abort_5_bytes   7654 3210 89AB CDEF 0000 0000 0000 1 0 0 5 01
after_abort     0000 0000 0000 0000 6A6A 9595 0001 0 1 0 16 02
long_18_bytes   1111 2222 3333 4444 5555 6666 7777 1 1 0 18 03
quat_only       8000 7FFF 0001 FFFF 0000 0000 0000 1 0 0 16 01
idle_no_strobe  0000 0000 0000 0000 0000 0000 0000 0 0 0 16 00

//--- test/imu_spi_link_assertions.sv
`timescale 1ns/10ps

module imu_spi_link_assertions
    import imu_link_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      cs_n,          // Raw select pin
    input logic      sdo_oe,        // Pad enable from the shifter
    input byte_idx_t byte_cnt       // Byte now being shifted
);

    // ----------------------------------------------------------------------
    // Pad enable
    // ----------------------------------------------------------------------
    // Output stays off through reset
    property oe_low_in_reset;
        @(posedge clk) !rst_n |=> !sdo_oe;
    endproperty

    // Select high for three samples, the synchronized select must be inactive
    property oe_drops_after_deselect;
        @(posedge clk) disable iff (!rst_n)
            (cs_n && $past(cs_n) && $past(cs_n, 2)) |-> !sdo_oe;
    endproperty

    // ----------------------------------------------------------------------
    // Byte counter range
    // ----------------------------------------------------------------------
    // Counter parks on the last byte while selected, no wrap back to 0
    property byte_cnt_in_frame;
        @(posedge clk) disable iff (!rst_n)
            (sdo_oe && byte_cnt == byte_idx_t'(frame_bytes - 1))
                |=> (byte_cnt == byte_idx_t'(frame_bytes - 1));
    endproperty

    assert property (oe_low_in_reset)
        else $error("sdo_oe high while rst_n is low");
    assert property (oe_drops_after_deselect)
        else $error("sdo_oe still high 2 cycles after cs_n went high");
    assert property (byte_cnt_in_frame)
        else $error("byte counter wrapped past 15");

endmodule

bind spi_miso_shifter imu_spi_link_assertions u_shift_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .cs_n     (cs_n),
    .sdo_oe   (sdo_oe),
    .byte_cnt (byte_cnt)
);

//--- test/imu_spi_link_tb.sv
`timescale 1ns/10ps

module imu_spi_link_tb
    import imu_link_pkg::*;
();

    // ----------------------------------------------------------------------
    // DUT connections
    // ----------------------------------------------------------------------
    logic                     clk;
    logic                     rst_n;
    logic                     cs_n;
    logic                     sck;
    logic                     quat_strobe;
    logic                     gyro_strobe;
    logic signed [word_w-1:0] quat_w;
    logic signed [word_w-1:0] quat_x;
    logic signed [word_w-1:0] quat_y;
    logic signed [word_w-1:0] quat_z;
    logic signed [word_w-1:0] gyro_x;
    logic signed [word_w-1:0] gyro_y;
    logic signed [word_w-1:0] gyro_z;
    logic                     sdo;
    logic                     sdo_oe;

    // Reference model state
    logic [word_w-1:0]           t_words [7];   // Words of the current input line
    logic [word_w-1:0]           m_words [7];   // Words the DUT should hold
    logic                        m_qf;          // Expected quaternion fresh flag
    logic                        m_gf;
    logic [0:frame_bytes-1][7:0] exp_frame;     // Byte 0 is sent first

    integer seed;                               // SCK half-period draws
    int     test_errs;
    int     pass_count;
    int     fail_count;
    string  cur_name;

    imu_spi_link_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cs_n        (cs_n),
        .sck         (sck),
        .quat_strobe (quat_strobe),
        .gyro_strobe (gyro_strobe),
        .quat_w      (quat_w),
        .quat_x      (quat_x),
        .quat_y      (quat_y),
        .quat_z      (quat_z),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z),
        .sdo         (sdo),
        .sdo_oe      (sdo_oe)
    );

    always #5 clk = ~clk;                       // 10 ns period

    // Global guard, the run cannot hang
    initial begin
        #2_000_000;
        $display("Simulation stopped by the watchdog before all tests finished");
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic tick();
        @(posedge clk);
        #1;                                     // Drive just after the edge
    endtask

    // One-cycle strobe with the line's words, model follows the same rule
    task automatic apply_sample(input logic qs, input logic gs);
        tick();
        quat_w      = t_words[0];
        quat_x      = t_words[1];
        quat_y      = t_words[2];
        quat_z      = t_words[3];
        gyro_x      = t_words[4];
        gyro_y      = t_words[5];
        gyro_z      = t_words[6];
        quat_strobe = qs;
        gyro_strobe = gs;
        tick();
        quat_strobe = 1'b0;
        gyro_strobe = 1'b0;
        if (qs) begin
            m_words[0] = t_words[0];
            m_words[1] = t_words[1];
            m_words[2] = t_words[2];
            m_words[3] = t_words[3];
            m_qf       = 1'b1;
        end
        if (gs) begin
            m_words[4] = t_words[4];
            m_words[5] = t_words[5];
            m_words[6] = t_words[6];
            m_gf       = 1'b1;
        end
    endtask

    // Frame as captured at chip select, then the flags count as reported
    task automatic capture_expected();
        exp_frame = {header_byte, m_words[0], m_words[1], m_words[2], m_words[3],
                     m_words[4], m_words[5], m_words[6], 6'b0, m_gf, m_qf};
        m_qf = 1'b0;
        m_gf = 1'b0;
    endtask

    function automatic logic [7:0] expected_at(input int b);
        byte_idx_t idx;
        idx = b[3:0];
        if (b >= frame_bytes)
            return 8'h00;                       // Zeros past the frame end
        return exp_frame[idx];
    endfunction

    // Random SCK half-period of 8 to 12 clk cycles
    task automatic sck_half();
        int n;
        n = 8 + int'($unsigned($random(seed)) % 5);
        repeat (n) tick();
    endtask

    task automatic wait_oe(input logic level, input int limit);
        int n;
        n = 0;
        while (sdo_oe !== level && n < limit) begin
            tick();
            n++;
        end
        assert (sdo_oe === level) else begin
            $display("%s: sdo_oe did not go to %b within %0d cycles", cur_name, level, limit);
            test_errs++;
        end
    endtask

    // ----------------------------------------------------------------------
    // SPI master, mode 0
    // ----------------------------------------------------------------------
    task automatic read_frame(input int nbytes, input logic mid, input logic qs,
                              input logic gs);
        logic [7:0] rx;
        logic [7:0] exp;
        capture_expected();
        tick();
        // Still deselected, pad must stay off
        assert (sdo_oe === 1'b0) else begin
            $display("FAIL %s idle sdo_oe expected 0 actual %b", cur_name, sdo_oe);
            test_errs++;
        end
        cs_n = 1'b0;
        repeat (6) tick();                      // Select setup
        for (int b = 0; b < nbytes; b++) begin
            rx = '0;
            for (int i = 0; i < 8; i++) begin
                if (mid && b == 2 && i == 0)
                    apply_sample(qs, gs);       // Sensor update mid frame
                sck_half();
                sck = 1'b1;
                rx  = {rx[6:0], sdo};           // Sample on the rising edge
                assert (sdo_oe === 1'b1) else begin
                    $display("FAIL %s sdo_oe expected 1 actual %b", cur_name, sdo_oe);
                    test_errs++;
                end
                sck_half();
                sck = 1'b0;                     // DUT shifts on this edge
            end
            exp = expected_at(b);
            assert (rx === exp) else begin
                $display("FAIL %s byte %0d expected %02h actual %02h", cur_name, b, exp, rx);
                test_errs++;
            end
        end
        sck_half();
        cs_n = 1'b1;
        wait_oe(1'b0, 4);
    endtask

    task automatic run_test(input int qs_i, input int gs_i, input int mid_i,
                            input int nbytes, input logic [7:0] exp_flags);
        test_errs = 0;
        if (mid_i == 0)
            apply_sample(qs_i != 0, gs_i != 0);
        // Flag column of the data file against the model
        assert ({6'b0, m_gf, m_qf} === exp_flags) else begin
            $display("FAIL %s flag byte expected %02h actual %02h (model)",
                     cur_name, exp_flags, {6'b0, m_gf, m_qf});
            test_errs++;
        end
        read_frame(nbytes, mid_i != 0, qs_i != 0, gs_i != 0);
        if (test_errs == 0) begin
            pass_count++;
            $display("[%s] ok, %0d bytes read", cur_name, nbytes);
        end else begin
            fail_count++;
            $display("[%s] FAILED with %0d errors", cur_name, test_errs);
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int         fd;
        int         n_fields;
        int         qs_i;
        int         gs_i;
        int         mid_i;
        int         nbytes;
        logic [7:0] exp_flags;
        string      line;
        string      name;

        seed        = 58559;
        clk         = 1'b0;
        rst_n       = 1'b0;
        cs_n        = 1'b1;                     // Deselected
        sck         = 1'b0;                     // Mode 0 idle level
        quat_strobe = 1'b0;
        gyro_strobe = 1'b0;
        quat_w      = '0;
        quat_x      = '0;
        quat_y      = '0;
        quat_z      = '0;
        gyro_x      = '0;
        gyro_y      = '0;
        gyro_z      = '0;
        for (int i = 0; i < 7; i++) begin
            t_words[i] = '0;
            m_words[i] = '0;                    // Held samples reset to zero
        end
        m_qf       = 1'b0;
        m_gf       = 1'b0;
        exp_frame  = '0;
        pass_count = 0;
        fail_count = 0;
        cur_name   = "reset";

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();
        assert (sdo_oe === 1'b0 && sdo === 1'b0) else begin
            $display("FAIL reset sdo_oe,sdo expected 0,0 actual %b,%b", sdo_oe, sdo);
            fail_count++;
        end

        fd = $fopen("test/frame_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/frame_input.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#")
                    continue;                   // Column notes and blank lines
                n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %d %d %d %d %h", name,
                                   t_words[0], t_words[1], t_words[2], t_words[3],
                                   t_words[4], t_words[5], t_words[6],
                                   qs_i, gs_i, mid_i, nbytes, exp_flags);
                if (n_fields != 13) begin
                    $display("Line in test/frame_input.txt has %0d fields, 13 expected",
                             n_fields);
                    fail_count++;
                end else begin
                    cur_name = name;
                    run_test(qs_i, gs_i, mid_i, nbytes, exp_flags);
                end
            end
            $fclose(fd);
        end

        $display("Summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
